//--- pad_ctrl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map and attribute layout of the pad ring.
// The attribute and mux windows hold at most MAX_PAD pads each.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pad_ctrl_pkg;

  // register bus geometry, in bits.
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // per-pad register widths.
  localparam int ATTR_W = 8;
  localparam int MUX_W  = 4;

  // the bus addresses whole registers, one per word.
  // attribute of pad p sits at ATTR_BASE + p.
  localparam logic [ADDR_W-1:0] ATTR_BASE = 8'h00;

  // mux select of pad p sits at MUX_BASE + p.
  localparam logic [ADDR_W-1:0] MUX_BASE = 8'h40;

  // bit 0 sets the lock, which only reset clears again.
  localparam logic [ADDR_W-1:0] LOCK_ADDR = 8'hFF;

  // the two attribute bits that the ring itself interprets.
  // bits 7:2 carry drive strength and pull to the pad cells as they are.
  localparam int ATTR_IN_EN_BIT  = 0;
  localparam int ATTR_OE_OFF_BIT = 1;

  // reset state: input enabled, output enable not forced off.
  localparam logic [ATTR_W-1:0] ATTR_RESET = 8'h01;

  // reset state: every pad is driven by function 0.
  localparam logic [MUX_W-1:0] MUX_RESET = 4'h0;

  // the attribute window ends where the mux window starts.
  localparam int MAX_PAD = 64;

endpackage

`default_nettype wire

//--- reg_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe bus: one response exactly one cycle after each request.
// No back-pressure, so the completer must always answer in time.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

  logic                              req_valid;
  logic                              req_write;
  logic [pad_ctrl_pkg::ADDR_W-1:0]   req_addr;
  logic [pad_ctrl_pkg::DATA_W-1:0]   req_wdata;

  logic                              rsp_valid;
  logic [pad_ctrl_pkg::DATA_W-1:0]   rsp_rdata;
  logic                              rsp_err;

  modport requester (
    output req_valid, req_write, req_addr, req_wdata,
    input  rsp_valid, rsp_rdata, rsp_err
  );

  modport completer (
    input  req_valid, req_write, req_addr, req_wdata,
    output rsp_valid, rsp_rdata, rsp_err
  );

endinterface

`default_nettype wire

//--- pad_in_sync.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-flop synchronizer, one bit per pad, no glitch filtering.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pad_in_sync #(
  parameter int NUM_PAD = 8
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [NUM_PAD-1:0] pad_in_i,
  input  logic [NUM_PAD-1:0] in_en_i,
  output logic [NUM_PAD-1:0] pad_in_sync_o
);

  logic [NUM_PAD-1:0] meta_q;
  logic [NUM_PAD-1:0] sync_q;

  // the enable gates the second stage so that a disabled pad reads zero
  // on the first edge after its attribute changes.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= pad_in_i;
      sync_q <= meta_q & in_en_i;
    end
  end

  assign pad_in_sync_o = sync_q;

endmodule

`default_nettype wire

//--- pad_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational function select for each pad.
// Selects at or above NUM_FUNC leave the pad undriven (zero).
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pad_mux #(
  parameter int NUM_PAD  = 8,
  parameter int NUM_FUNC = 4
) (
  input  logic [NUM_FUNC-1:0][NUM_PAD-1:0]               func_out_i,
  input  logic [NUM_FUNC-1:0][NUM_PAD-1:0]               func_oe_i,
  output logic [NUM_FUNC-1:0][NUM_PAD-1:0]               func_in_o,
  input  logic [NUM_PAD-1:0][pad_ctrl_pkg::MUX_W-1:0]    pad_mux_i,
  input  logic [NUM_PAD-1:0][pad_ctrl_pkg::ATTR_W-1:0]   pad_attr_i,
  input  logic [NUM_PAD-1:0]                             pad_in_i,
  output logic [NUM_PAD-1:0]                             pad_out_o,
  output logic [NUM_PAD-1:0]                             pad_oe_o
);

  localparam int MW = pad_ctrl_pkg::MUX_W;

  if (NUM_FUNC < 1 || NUM_FUNC > (1 << MW)) begin : g_num_func_check
    $error("pad_mux: NUM_FUNC does not fit the mux select width");
  end

  always_comb begin
    pad_out_o = '0;
    pad_oe_o  = '0;
    func_in_o = '0;
    for (int p = 0; p < NUM_PAD; p++) begin
      for (int f = 0; f < NUM_FUNC; f++) begin
        if (int'(pad_mux_i[p]) == f) begin
          pad_out_o[p] = func_out_i[f][p];
          pad_oe_o[p]  = func_oe_i[f][p] & ~pad_attr_i[p][pad_ctrl_pkg::ATTR_OE_OFF_BIT];
          // the input goes back only to the function that owns the pad.
          func_in_o[f][p] = pad_in_i[p];
        end
      end
      // a pad with no valid function must never be driven.
      assert (int'(pad_mux_i[p]) < NUM_FUNC || !pad_oe_o[p])
        else $error("pad_mux: pad %0d driven with out of range select", p);
    end
  end

endmodule

`default_nettype wire

//--- pad_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad configuration registers behind the strobe bus.
// Once locked, writes fail with an error until the next reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pad_control #(
  parameter int NUM_PAD = 8
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  reg_bus_if.completer                                  bus,
  output logic [NUM_PAD-1:0][pad_ctrl_pkg::ATTR_W-1:0]  pad_attributes_o,
  output logic [NUM_PAD-1:0][pad_ctrl_pkg::MUX_W-1:0]   pad_muxes_o
);

  localparam int AW  = pad_ctrl_pkg::ADDR_W;
  localparam int DW  = pad_ctrl_pkg::DATA_W;
  localparam int ATW = pad_ctrl_pkg::ATTR_W;
  localparam int MW  = pad_ctrl_pkg::MUX_W;

  logic [NUM_PAD-1:0][ATW-1:0] attr_q;
  logic [NUM_PAD-1:0][MW-1:0]  mux_q;
  logic                        lock_q;

  logic [AW-1:0]               attr_off;
  logic [AW-1:0]               mux_off;
  logic [NUM_PAD-1:0]          attr_sel;
  logic [NUM_PAD-1:0]          mux_sel;
  logic                        lock_sel;
  logic                        req_err;
  logic                        wr_en;
  logic [DW-1:0]               rd_data;

  if (NUM_PAD < 1 || NUM_PAD > pad_ctrl_pkg::MAX_PAD) begin : g_num_pad_check
    $error("pad_control: NUM_PAD must be between 1 and MAX_PAD");
  end

  // offsets wrap below the base, so a single compare per pad is enough.
  assign attr_off = bus.req_addr - pad_ctrl_pkg::ATTR_BASE;
  assign mux_off  = bus.req_addr - pad_ctrl_pkg::MUX_BASE;
  assign lock_sel = (bus.req_addr == pad_ctrl_pkg::LOCK_ADDR);

  always_comb begin
    attr_sel = '0;
    mux_sel  = '0;
    rd_data  = '0;
    for (int p = 0; p < NUM_PAD; p++) begin
      if (attr_off == AW'(p)) begin
        attr_sel[p] = 1'b1;
        rd_data     = DW'(attr_q[p]);
      end
      if (mux_off == AW'(p)) begin
        mux_sel[p] = 1'b1;
        rd_data    = DW'(mux_q[p]);
      end
    end
    if (lock_sel) begin
      rd_data = DW'(lock_q);
    end
  end

  // unmapped addresses always fail; mapped ones fail only for writes under lock.
  assign req_err = ~((|attr_sel) | (|mux_sel) | lock_sel) | (bus.req_write & lock_q);
  assign wr_en   = bus.req_valid & bus.req_write & ~req_err;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      attr_q <= {NUM_PAD{pad_ctrl_pkg::ATTR_RESET}};
      mux_q  <= {NUM_PAD{pad_ctrl_pkg::MUX_RESET}};
      lock_q <= 1'b0;
    end else if (wr_en) begin
      for (int p = 0; p < NUM_PAD; p++) begin
        if (attr_sel[p]) begin
          attr_q[p] <= bus.req_wdata[ATW-1:0];
        end
        if (mux_sel[p]) begin
          mux_q[p] <= bus.req_wdata[MW-1:0];
        end
      end
      if (lock_sel && bus.req_wdata[0]) begin
        lock_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus.rsp_valid <= 1'b0;
      bus.rsp_err   <= 1'b0;
    end else begin
      bus.rsp_valid <= bus.req_valid;
      bus.rsp_err   <= bus.req_valid & req_err;
    end
  end

  // writes and failed requests return zero data.
  always_ff @(posedge clk_i) begin
    bus.rsp_rdata <= (bus.req_write | req_err) ? '0 : rd_data;
  end

  assign pad_attributes_o = attr_q;
  assign pad_muxes_o      = mux_q;

  // each request is answered on the following edge and nothing else is.
  assert property (@(posedge clk_i)
    !$past(rst_i) |-> (bus.rsp_valid == $past(bus.req_valid)))
    else $error("pad_control: response not one cycle after request");

  assert property (@(posedge clk_i) (!$past(rst_i) && $past(lock_q)) |-> lock_q)
    else $error("pad_control: lock cleared outside reset");

endmodule

`default_nettype wire

//--- pad_ring.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad ring top. Pads are numbered 0 to NUM_PAD-1, functions
// 0 to NUM_FUNC-1; analog pads are not handled here.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pad_ring #(
  parameter int NUM_PAD  = 8,
  parameter int NUM_FUNC = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,

  input  logic                                          req_valid_i,
  input  logic                                          req_write_i,
  input  logic [pad_ctrl_pkg::ADDR_W-1:0]               req_addr_i,
  input  logic [pad_ctrl_pkg::DATA_W-1:0]               req_wdata_i,
  output logic                                          rsp_valid_o,
  output logic [pad_ctrl_pkg::DATA_W-1:0]               rsp_rdata_o,
  output logic                                          rsp_err_o,

  input  logic [NUM_FUNC-1:0][NUM_PAD-1:0]              func_out_i,
  input  logic [NUM_FUNC-1:0][NUM_PAD-1:0]              func_oe_i,
  output logic [NUM_FUNC-1:0][NUM_PAD-1:0]              func_in_o,

  input  logic [NUM_PAD-1:0]                            pad_in_i,
  output logic [NUM_PAD-1:0]                            pad_out_o,
  output logic [NUM_PAD-1:0]                            pad_oe_o,
  output logic [NUM_PAD-1:0][pad_ctrl_pkg::ATTR_W-1:0]  pad_attributes_o,
  output logic [NUM_PAD-1:0][pad_ctrl_pkg::MUX_W-1:0]   pad_muxes_o
);

  logic [NUM_PAD-1:0][pad_ctrl_pkg::ATTR_W-1:0] attr;
  logic [NUM_PAD-1:0][pad_ctrl_pkg::MUX_W-1:0]  mux;
  logic [NUM_PAD-1:0]                           in_en;
  logic [NUM_PAD-1:0]                           pad_in_sync;

  reg_bus_if bus ();

  assign bus.req_valid = req_valid_i;
  assign bus.req_write = req_write_i;
  assign bus.req_addr  = req_addr_i;
  assign bus.req_wdata = req_wdata_i;
  assign rsp_valid_o   = bus.rsp_valid;
  assign rsp_rdata_o   = bus.rsp_rdata;
  assign rsp_err_o     = bus.rsp_err;

  for (genvar p = 0; p < NUM_PAD; p++) begin : g_in_en
    assign in_en[p] = attr[p][pad_ctrl_pkg::ATTR_IN_EN_BIT];
  end

  pad_control #(
    .NUM_PAD (NUM_PAD)
  ) u_pad_control (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .bus              (bus.completer),
    .pad_attributes_o (attr),
    .pad_muxes_o      (mux)
  );

  pad_in_sync #(
    .NUM_PAD (NUM_PAD)
  ) u_pad_in_sync (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .pad_in_i      (pad_in_i),
    .in_en_i       (in_en),
    .pad_in_sync_o (pad_in_sync)
  );

  pad_mux #(
    .NUM_PAD  (NUM_PAD),
    .NUM_FUNC (NUM_FUNC)
  ) u_pad_mux (
    .func_out_i (func_out_i),
    .func_oe_i  (func_oe_i),
    .func_in_o  (func_in_o),
    .pad_mux_i  (mux),
    .pad_attr_i (attr),
    .pad_in_i   (pad_in_sync),
    .pad_out_o  (pad_out_o),
    .pad_oe_o   (pad_oe_o)
  );

  assign pad_attributes_o = attr;
  assign pad_muxes_o      = mux;

endmodule

`default_nettype wire

//--- tb_pad_ring.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for pad_ring with 8 pads and 4 functions.
// Register data and pin stimulus come from a 16-bit Galois LFSR.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_pad_ring;

  localparam int NUM_PAD  = 8;
  localparam int NUM_FUNC = 4;
  localparam int AW       = pad_ctrl_pkg::ADDR_W;
  localparam int DW       = pad_ctrl_pkg::DATA_W;
  localparam int ATW      = pad_ctrl_pkg::ATTR_W;
  localparam int MW       = pad_ctrl_pkg::MUX_W;

  // cycle budgets of reset and of the five tests, in order.
  localparam int CYCLE_BUDGET = 20 + 40 + 100 + 100 + 140 + 100;
  localparam int WATCHDOG_NS  = 20 * CYCLE_BUDGET * 10;

  logic                              clk_i;
  logic                              rst_i;
  logic                              req_valid_i;
  logic                              req_write_i;
  logic [AW-1:0]                     req_addr_i;
  logic [DW-1:0]                     req_wdata_i;
  logic                              rsp_valid_o;
  logic [DW-1:0]                     rsp_rdata_o;
  logic                              rsp_err_o;
  logic [NUM_FUNC-1:0][NUM_PAD-1:0]  func_out_i;
  logic [NUM_FUNC-1:0][NUM_PAD-1:0]  func_oe_i;
  logic [NUM_FUNC-1:0][NUM_PAD-1:0]  func_in_o;
  logic [NUM_PAD-1:0]                pad_in_i;
  logic [NUM_PAD-1:0]                pad_out_o;
  logic [NUM_PAD-1:0]                pad_oe_o;
  logic [NUM_PAD-1:0][ATW-1:0]       pad_attributes_o;
  logic [NUM_PAD-1:0][MW-1:0]        pad_muxes_o;

  logic [15:0]    lfsr_q;
  int             error_count;
  int             tests_run;
  logic [ATW-1:0] exp_attr [NUM_PAD];
  logic [MW-1:0]  exp_mux  [NUM_PAD];
  logic           exp_lock;

  pad_ring #(
    .NUM_PAD  (NUM_PAD),
    .NUM_FUNC (NUM_FUNC)
  ) dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_valid_i),
    .req_write_i      (req_write_i),
    .req_addr_i       (req_addr_i),
    .req_wdata_i      (req_wdata_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_rdata_o      (rsp_rdata_o),
    .rsp_err_o        (rsp_err_o),
    .func_out_i       (func_out_i),
    .func_oe_i        (func_oe_i),
    .func_in_o        (func_in_o),
    .pad_in_i         (pad_in_i),
    .pad_out_o        (pad_out_o),
    .pad_oe_o         (pad_oe_o),
    .pad_attributes_o (pad_attributes_o),
    .pad_muxes_o      (pad_muxes_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  // one LFSR step per bit, the low bit of the state is taken each time.
  task automatic rand_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value  = {value[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // called on a falling edge; the response is sampled one cycle later.
  task automatic bus_access(input logic wr, input logic [AW-1:0] addr,
                            input logic [DW-1:0] wdata, input logic exp_err,
                            output logic [DW-1:0] rdata);
    req_valid_i = 1'b1;
    req_write_i = wr;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (rsp_valid_o !== 1'b1) begin
      report_mismatch($sformatf("no response for address %h", addr));
    end
    if (rsp_err_o !== exp_err) begin
      report_mismatch($sformatf("address %h rsp_err %b, expected %b", addr, rsp_err_o, exp_err));
    end
    if ((wr || exp_err) && rsp_rdata_o !== '0) begin
      report_mismatch($sformatf("address %h returned data %h, expected 0", addr, rsp_rdata_o));
    end
    rdata = rsp_rdata_o;
  endtask

  task automatic bus_write(input logic [AW-1:0] addr, input logic [DW-1:0] wdata,
                           input logic exp_err);
    logic [DW-1:0] unused_rdata;
    bus_access(1'b1, addr, wdata, exp_err, unused_rdata);
  endtask

  task automatic bus_read(input logic [AW-1:0] addr, input logic exp_err,
                          output logic [DW-1:0] rdata);
    bus_access(1'b0, addr, '0, exp_err, rdata);
  endtask

  task automatic idle_check();
    @(negedge clk_i);
    if (rsp_valid_o !== 1'b0 || rsp_err_o !== 1'b0) begin
      report_mismatch("response seen without a request");
    end
  endtask

  task automatic check_config_outputs(input string when);
    for (int p = 0; p < NUM_PAD; p++) begin
      if (pad_attributes_o[p] !== exp_attr[p]) begin
        report_mismatch($sformatf("%s: pad %0d attribute %h, expected %h",
                                  when, p, pad_attributes_o[p], exp_attr[p]));
      end
      if (pad_muxes_o[p] !== exp_mux[p]) begin
        report_mismatch($sformatf("%s: pad %0d mux %h, expected %h",
                                  when, p, pad_muxes_o[p], exp_mux[p]));
      end
    end
  endtask

  // reads every register back and compares it with the model.
  task automatic check_readback(input string when);
    logic [DW-1:0] rd;
    for (int p = 0; p < NUM_PAD; p++) begin
      bus_read(pad_ctrl_pkg::ATTR_BASE + AW'(p), 1'b0, rd);
      if (rd !== DW'(exp_attr[p])) begin
        report_mismatch($sformatf("%s: attr %0d read %h", when, p, rd));
      end
      bus_read(pad_ctrl_pkg::MUX_BASE + AW'(p), 1'b0, rd);
      if (rd !== DW'(exp_mux[p])) begin
        report_mismatch($sformatf("%s: mux %0d read %h", when, p, rd));
      end
    end
    bus_read(pad_ctrl_pkg::LOCK_ADDR, 1'b0, rd);
    if (rd !== DW'(exp_lock)) begin
      report_mismatch($sformatf("%s: lock read %h, expected %b", when, rd, exp_lock));
    end
  endtask

  task automatic reset_values_test();
    tests_run++;
    if (rsp_valid_o !== 1'b0 || rsp_err_o !== 1'b0) begin
      report_mismatch("response flags not clear after reset");
    end
    check_config_outputs("reset");
    check_readback("reset");
  endtask

  task automatic reg_write_read_test();
    logic [31:0] r;
    tests_run++;
    // back-to-back writes, each output checked one cycle after its strobe.
    for (int p = 0; p < NUM_PAD; p++) begin
      rand_bits(DW, r);
      exp_attr[p] = r[ATW-1:0];
      bus_write(pad_ctrl_pkg::ATTR_BASE + AW'(p), r, 1'b0);
      if (pad_attributes_o[p] !== exp_attr[p]) begin
        report_mismatch($sformatf("pad %0d attribute not updated after write", p));
      end
      rand_bits(DW, r);
      exp_mux[p] = r[MW-1:0];
      bus_write(pad_ctrl_pkg::MUX_BASE + AW'(p), r, 1'b0);
      if (pad_muxes_o[p] !== exp_mux[p]) begin
        report_mismatch($sformatf("pad %0d mux not updated after write", p));
      end
    end
    check_readback("write and read");
    idle_check();
  endtask

  task automatic output_select_test();
    logic [31:0] r;
    logic [1:0]  fn;
    logic        exp_out;
    logic        exp_oe;
    tests_run++;
    for (int round = 0; round < 4; round++) begin
      for (int p = 0; p < NUM_PAD; p++) begin
        rand_bits(MW, r);
        exp_mux[p] = r[MW-1:0];
        bus_write(pad_ctrl_pkg::MUX_BASE + AW'(p), r, 1'b0);
        rand_bits(ATW, r);
        exp_attr[p] = r[ATW-1:0];
        bus_write(pad_ctrl_pkg::ATTR_BASE + AW'(p), r, 1'b0);
      end
      for (int k = 0; k < 3; k++) begin
        rand_bits(NUM_FUNC * NUM_PAD, r);
        func_out_i = r;
        rand_bits(NUM_FUNC * NUM_PAD, r);
        func_oe_i = r;
        @(negedge clk_i);
        for (int p = 0; p < NUM_PAD; p++) begin
          exp_out = 1'b0;
          exp_oe  = 1'b0;
          if (int'(exp_mux[p]) < NUM_FUNC) begin
            fn      = exp_mux[p][1:0];
            exp_out = func_out_i[fn][p];
            exp_oe  = func_oe_i[fn][p] & ~exp_attr[p][pad_ctrl_pkg::ATTR_OE_OFF_BIT];
          end
          if (pad_out_o[p] !== exp_out || pad_oe_o[p] !== exp_oe) begin
            report_mismatch($sformatf("pad %0d sel %0d out %b oe %b, expected %b %b",
                                      p, exp_mux[p], pad_out_o[p], pad_oe_o[p],
                                      exp_out, exp_oe));
          end
        end
      end
    end
  endtask

  task automatic check_func_in(input logic [NUM_PAD-1:0] val, input string when);
    logic exp_in;
    for (int p = 0; p < NUM_PAD; p++) begin
      for (int f = 0; f < NUM_FUNC; f++) begin
        exp_in = (int'(exp_mux[p]) == f) && exp_attr[p][pad_ctrl_pkg::ATTR_IN_EN_BIT]
                 && val[p];
        if (func_in_o[f][p] !== exp_in) begin
          report_mismatch($sformatf("%s: func %0d pad %0d input %b, expected %b",
                                    when, f, p, func_in_o[f][p], exp_in));
        end
      end
    end
  endtask

  task automatic input_path_test();
    logic [31:0]        r;
    logic [NUM_PAD-1:0] prev;
    tests_run++;
    for (int round = 0; round < 4; round++) begin
      for (int p = 0; p < NUM_PAD; p++) begin
        // three bits reach past NUM_FUNC, so some pads have no owner.
        rand_bits(3, r);
        exp_mux[p] = r[MW-1:0];
        bus_write(pad_ctrl_pkg::MUX_BASE + AW'(p), r, 1'b0);
        rand_bits(ATW, r);
        exp_attr[p] = r[ATW-1:0];
        bus_write(pad_ctrl_pkg::ATTR_BASE + AW'(p), r, 1'b0);
      end
      prev = pad_in_i;
      repeat (2) @(negedge clk_i);
      rand_bits(NUM_PAD, r);
      pad_in_i = r[NUM_PAD-1:0];
      @(negedge clk_i);
      check_func_in(prev, "one edge");
      @(negedge clk_i);
      check_func_in(pad_in_i, "two edges");
    end
    // clearing the input enable zeroes pad 0 one edge after the write.
    exp_attr[0] = pad_ctrl_pkg::ATTR_RESET;
    exp_mux[0]  = pad_ctrl_pkg::MUX_RESET;
    bus_write(pad_ctrl_pkg::ATTR_BASE, DW'(exp_attr[0]), 1'b0);
    bus_write(pad_ctrl_pkg::MUX_BASE, DW'(exp_mux[0]), 1'b0);
    pad_in_i = '1;
    repeat (2) @(negedge clk_i);
    check_func_in(pad_in_i, "enabled");
    exp_attr[0] = 8'h00;
    bus_write(pad_ctrl_pkg::ATTR_BASE, 32'h0, 1'b0);
    if (func_in_o[0][0] !== 1'b1) begin
      report_mismatch("pad 0 input cleared before the enable took effect");
    end
    @(negedge clk_i);
    if (func_in_o[0][0] !== 1'b0) begin
      report_mismatch("pad 0 input not cleared one edge after disable");
    end
  endtask

  task automatic error_lock_test();
    logic [AW-1:0] bad_addr [5];
    logic [DW-1:0] rd;
    logic [31:0]   r;
    tests_run++;
    bad_addr[0] = pad_ctrl_pkg::ATTR_BASE + AW'(NUM_PAD);
    bad_addr[1] = pad_ctrl_pkg::MUX_BASE - 8'h01;
    bad_addr[2] = pad_ctrl_pkg::MUX_BASE + AW'(NUM_PAD);
    bad_addr[3] = 8'h80;
    bad_addr[4] = pad_ctrl_pkg::LOCK_ADDR - 8'h01;
    for (int i = 0; i < 5; i++) begin
      bus_read(bad_addr[i], 1'b1, rd);
      rand_bits(DW, r);
      bus_write(bad_addr[i], r, 1'b1);
      check_config_outputs("unmapped write");
    end
    exp_lock = 1'b1;
    bus_write(pad_ctrl_pkg::LOCK_ADDR, 32'h1, 1'b0);
    for (int p = 0; p < NUM_PAD; p++) begin
      rand_bits(DW, r);
      bus_write(pad_ctrl_pkg::ATTR_BASE + AW'(p), r, 1'b1);
      rand_bits(DW, r);
      bus_write(pad_ctrl_pkg::MUX_BASE + AW'(p), r, 1'b1);
    end
    bus_write(pad_ctrl_pkg::LOCK_ADDR, 32'h0, 1'b1);
    check_config_outputs("locked write");
    check_readback("locked");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: the tests did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    func_out_i  = '0;
    func_oe_i   = '0;
    pad_in_i    = '0;
    lfsr_q      = 16'd56;
    error_count = 0;
    tests_run   = 0;
    exp_lock    = 1'b0;
    for (int p = 0; p < NUM_PAD; p++) begin
      exp_attr[p] = pad_ctrl_pkg::ATTR_RESET;
      exp_mux[p]  = pad_ctrl_pkg::MUX_RESET;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    reset_values_test();
    reg_write_read_test();
    output_select_test();
    input_path_test();
    error_lock_test();

    $display("tests run: %0d, errors: %0d", tests_run, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
pad_ctrl_pkg.sv
reg_bus_if.sv
pad_in_sync.sv
pad_mux.sv
pad_control.sv
pad_ring.sv
tb_pad_ring.sv

//--- Makefile
# Verilator simulation of the pad ring testbench.
# The run fails when the log holds the fail message or lacks the pass message.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_pad_ring \
		-f files.f --Mdir obj_dir -o tb_pad_ring
	./obj_dir/tb_pad_ring | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
